// ==== hw/cam_settings.svh ====
// width, depth and address size macros of the camera interface
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH

`define CAM_DATA_W      8   // camera byte
`define CAM_CNT_W       16  // row and column counters
`define CAM_COEFF_W     8
`define CAM_SHIFT_W     4
`define CAM_FRAMEDROP_W 6
`define CAM_WORD_W      32  // output word
`define CAM_FIFO_DEPTH  4
`define CAM_CFG_ADDR_W  5

`endif

// ==== hw/cam_cfg_pkg.sv ====
// register map enum and configuration field types
`include "cam_settings.svh"

package cam_cfg_pkg;

    // one 32-bit word per register
    typedef enum logic [`CAM_CFG_ADDR_W-1:0] {
        REG_GLOB      = 0,
        REG_LL        = 1,
        REG_UR        = 2,
        REG_SIZE      = 3,
        REG_FILTER    = 4,
        REG_VSYNC_POL = 5,
        REG_STATUS    = 6   // read only
    } cfg_addr_e;

    typedef logic [`CAM_CNT_W-1:0]       cnt_t;
    typedef logic [`CAM_COEFF_W-1:0]     coeff_t;
    typedef logic [`CAM_SHIFT_W-1:0]     shift_t;
    typedef logic [`CAM_FRAMEDROP_W-1:0] frdrop_t;
    typedef logic [31:0]                 cfg_word_t;

endpackage

// ==== hw/cam_pix_pkg.sv ====
// pixel format enum and pixel data types
`include "cam_settings.svh"

package cam_pix_pkg;

    typedef enum logic [2:0] {
        RGB565 = 3'b000,
        RGB555 = 3'b001,
        RGB444 = 3'b010,
        BYP_LE = 3'b100,   // codes with bit 2 set bypass the filter
        BYP_BE = 3'b101
    } pix_format_e;

    typedef logic [`CAM_DATA_W-1:0] pix_byte_t;
    typedef logic [7:0]             chan_t;
    typedef logic [16:0]            filt_t;   // sum of three weighted channels
    typedef logic [`CAM_WORD_W-1:0] out_word_t;

endpackage

// ==== hw/cam_reg_file.sv ====
// configuration registers, field split and status readback
`include "cam_settings.svh"

module cam_reg_file (
    input  logic                     s_cam_clk_dft,
    input  logic                     rstn_i,
    input  logic                     cfg_valid_i,
    input  logic                     cfg_rwn_i,
    input  cam_cfg_pkg::cfg_addr_e   cfg_addr_i,
    input  cam_cfg_pkg::cfg_word_t   cfg_data_i,
    input  cam_cfg_pkg::cnt_t        drop_count_i,
    output cam_cfg_pkg::cfg_word_t   cfg_data_o,
    output logic                     cfg_ready_o,
    output logic                     capture_en_o,
    output logic                     framedrop_en_o,
    output cam_cfg_pkg::frdrop_t     framedrop_val_o,
    output logic                     slice_en_o,
    output cam_cfg_pkg::cnt_t        slice_llx_o,
    output cam_cfg_pkg::cnt_t        slice_lly_o,
    output cam_cfg_pkg::cnt_t        slice_urx_o,
    output cam_cfg_pkg::cnt_t        slice_ury_o,
    output cam_cfg_pkg::cnt_t        rowlen_o,
    output cam_pix_pkg::pix_format_e format_o,
    output cam_cfg_pkg::shift_t      shift_o,
    output cam_cfg_pkg::coeff_t      coeff_r_o,
    output cam_cfg_pkg::coeff_t      coeff_g_o,
    output cam_cfg_pkg::coeff_t      coeff_b_o,
    output logic                     vsync_pol_o
);
    import cam_cfg_pkg::*;
    import cam_pix_pkg::*;

    cfg_word_t r_glob;
    cfg_word_t r_ll;
    cfg_word_t r_ur;
    cfg_word_t r_size;
    cfg_word_t r_filter;
    logic      r_vsync_pol;
    cfg_word_t s_rdata;

    always_comb begin
        case (cfg_addr_i)
            REG_GLOB:      s_rdata = r_glob;
            REG_LL:        s_rdata = r_ll;
            REG_UR:        s_rdata = r_ur;
            REG_SIZE:      s_rdata = r_size;
            REG_FILTER:    s_rdata = r_filter;
            REG_VSYNC_POL: s_rdata = {31'b0, r_vsync_pol};
            REG_STATUS:    s_rdata = cfg_word_t'(drop_count_i);
            default:       s_rdata = '0;   // unmapped
        endcase
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            r_glob      <= '0;
            r_ll        <= '0;
            r_ur        <= '0;
            r_size      <= '0;
            r_filter    <= '0;
            r_vsync_pol <= 1'b0;
        end else if (cfg_valid_i && !cfg_rwn_i) begin
            case (cfg_addr_i)
                REG_GLOB:      r_glob      <= cfg_data_i;
                REG_LL:        r_ll        <= cfg_data_i;
                REG_UR:        r_ur        <= cfg_data_i;
                REG_SIZE:      r_size      <= cfg_data_i;
                REG_FILTER:    r_filter    <= cfg_data_i;
                REG_VSYNC_POL: r_vsync_pol <= cfg_data_i[0];
                default:       ;           // status and unmapped ignore writes
            endcase
        end
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_ready_o <= 1'b0;
            cfg_data_o  <= '0;
        end else begin
            cfg_ready_o <= cfg_valid_i;
            cfg_data_o  <= (cfg_valid_i && cfg_rwn_i) ? s_rdata : '0;
        end
    end

    assign framedrop_en_o  = r_glob[0];
    assign framedrop_val_o = r_glob[6:1];
    assign slice_en_o      = r_glob[7];
    assign format_o        = pix_format_e'(r_glob[10:8]);
    assign shift_o         = r_glob[14:11];
    assign capture_en_o    = r_glob[31];
    assign slice_llx_o     = r_ll[15:0];
    assign slice_lly_o     = r_ll[31:16];
    assign slice_urx_o     = r_ur[15:0];
    assign slice_ury_o     = r_ur[31:16];
    assign rowlen_o        = r_size[31:16];
    assign coeff_r_o       = r_filter[23:16];
    assign coeff_g_o       = r_filter[15:8];
    assign coeff_b_o       = r_filter[7:0];
    assign vsync_pol_o     = r_vsync_pol;

    // host sees exactly one ready per request, one cycle later
    a_ready_follows_valid : assert property (
        @(posedge s_cam_clk_dft) disable iff (!rstn_i)
        cfg_valid_i |=> cfg_ready_o
    );
    a_no_spurious_ready : assert property (
        @(posedge s_cam_clk_dft) disable iff (!rstn_i)
        !cfg_valid_i |=> !cfg_ready_o
    );

endmodule

// ==== hw/cam_frame_ctrl.sv ====
// frame edges, capture enable, decimation, slice window and byte pairing
`include "cam_settings.svh"

module cam_frame_ctrl (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  cam_pix_pkg::pix_byte_t cam_data_i,
    input  logic                   cam_hsync_i,
    input  logic                   cam_vsync_i,
    input  logic                   capture_en_i,
    input  logic                   vsync_pol_i,
    input  logic                   framedrop_en_i,
    input  cam_cfg_pkg::frdrop_t   framedrop_val_i,
    input  logic                   slice_en_i,
    input  cam_cfg_pkg::cnt_t      slice_llx_i,
    input  cam_cfg_pkg::cnt_t      slice_lly_i,
    input  cam_cfg_pkg::cnt_t      slice_urx_i,
    input  cam_cfg_pkg::cnt_t      slice_ury_i,
    input  cam_cfg_pkg::cnt_t      rowlen_i,
    output logic                   pair_valid_o,
    output cam_pix_pkg::pix_byte_t pair_msb_o,
    output cam_pix_pkg::pix_byte_t pair_lsb_o,
    output logic                   flush_o,
    output logic                   frame_evt_o
);
    import cam_cfg_pkg::*;
    import cam_pix_pkg::*;

    logic      s_vsync;
    logic      r_vsync;
    logic      s_sof;
    logic      s_eof;
    logic      r_enable;
    frdrop_t   r_framecnt;
    logic      r_sample_msb;
    pix_byte_t r_data_msb;
    cnt_t      r_col;
    cnt_t      r_row;
    logic      s_in_window;
    logic      s_second;

    assign s_vsync  = vsync_pol_i ? ~cam_vsync_i : cam_vsync_i;
    assign s_sof    = s_vsync & ~r_vsync;
    assign s_eof    = ~s_vsync & r_vsync;
    assign s_second = cam_hsync_i & r_enable & ~r_sample_msb;

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            r_vsync     <= 1'b0;
            frame_evt_o <= 1'b0;
            flush_o     <= 1'b1;
            r_enable    <= 1'b0;
            r_framecnt  <= '0;
        end else begin
            r_vsync     <= s_vsync;
            frame_evt_o <= s_eof;
            flush_o     <= ~capture_en_i;
            if (s_sof) begin
                r_enable <= capture_en_i;   // enable only at frame start
            end else if (!capture_en_i) begin
                r_enable <= 1'b0;
            end
            if (!capture_en_i) begin
                r_framecnt <= '0;
            end else if (s_sof && r_enable) begin
                if (!framedrop_en_i || r_framecnt == framedrop_val_i) begin
                    r_framecnt <= '0;
                end else begin
                    r_framecnt <= r_framecnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            r_sample_msb <= 1'b1;
        end else if (!r_enable || !cam_hsync_i) begin
            r_sample_msb <= 1'b1;   // every line starts on a first byte
        end else begin
            r_sample_msb <= ~r_sample_msb;
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (cam_hsync_i && r_enable && r_sample_msb) begin
            r_data_msb <= cam_data_i;
        end
    end

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            r_col <= '0;
            r_row <= '0;
        end else if (s_sof || !capture_en_i) begin
            r_col <= '0;
            r_row <= '0;
        end else if (s_second && slice_en_i) begin
            if (r_col == rowlen_i) begin
                r_col <= '0;
                r_row <= r_row + 1'b1;
            end else begin
                r_col <= r_col + 1'b1;
            end
        end
    end

    assign s_in_window = !slice_en_i ||
                         (r_row >= slice_lly_i && r_row <= slice_ury_i &&
                          r_col >= slice_llx_i && r_col <= slice_urx_i);

    assign pair_valid_o = s_second && (r_framecnt == '0) && s_in_window;
    assign pair_msb_o   = r_data_msb;
    assign pair_lsb_o   = cam_data_i;

    a_sof_eof_exclusive : assert property (
        @(posedge s_cam_clk_dft) disable iff (!rstn_i)
        !(s_sof && s_eof)
    );

endmodule

// ==== hw/cam_pixel_proc.sv ====
// format decode, grayscale filter, shift and output word pipeline
`include "cam_settings.svh"

module cam_pixel_proc (
    input  logic                     s_cam_clk_dft,
    input  logic                     rstn_i,
    input  logic                     pair_valid_i,
    input  cam_pix_pkg::pix_byte_t   pair_msb_i,
    input  cam_pix_pkg::pix_byte_t   pair_lsb_i,
    input  cam_pix_pkg::pix_format_e format_i,
    input  cam_cfg_pkg::shift_t      shift_i,
    input  cam_cfg_pkg::coeff_t      coeff_r_i,
    input  cam_cfg_pkg::coeff_t      coeff_g_i,
    input  cam_cfg_pkg::coeff_t      coeff_b_i,
    output logic                     word_valid_o,
    output cam_pix_pkg::out_word_t   word_o
);
    import cam_pix_pkg::*;

    chan_t       s_r;
    chan_t       s_g;
    chan_t       s_b;
    chan_t       r_r;
    chan_t       r_g;
    chan_t       r_b;
    logic        r_rgb_valid;
    logic [15:0] s_byp;
    logic [15:0] r_byp;
    logic        r_byp_valid;
    filt_t       s_filt;
    filt_t       r_filt;
    logic        r_filt_valid;
    logic [15:0] s_shifted;

    always_comb begin
        s_r   = '0;
        s_g   = '0;
        s_b   = '0;
        s_byp = {pair_msb_i, pair_lsb_i};   // little endian and unused codes
        case (format_i)
            RGB565: begin
                s_r = {pair_msb_i[7:3], 3'b000};
                s_g = {pair_msb_i[2:0], pair_lsb_i[7:5], 2'b00};
                s_b = {pair_lsb_i[4:0], 3'b000};
            end
            RGB555: begin
                s_r = {pair_msb_i[6:2], 3'b000};
                s_g = {pair_msb_i[1:0], pair_lsb_i[7:5], 3'b000};
                s_b = {pair_lsb_i[4:0], 3'b000};
            end
            RGB444: begin
                s_r = {pair_msb_i[3:0], 4'b0000};
                s_g = {pair_lsb_i[7:4], 4'b0000};
                s_b = {pair_lsb_i[3:0], 4'b0000};
            end
            BYP_BE:  s_byp = {pair_lsb_i, pair_msb_i};
            default: ;
        endcase
    end

    assign s_filt = filt_t'(r_r) * coeff_r_i + filt_t'(r_g) * coeff_g_i +
                    filt_t'(r_b) * coeff_b_i;

    // shifts above 9 fall back to no shift
    assign s_shifted = (shift_i > 4'd9) ? r_filt[15:0] : 16'(r_filt >> shift_i);

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            r_rgb_valid  <= 1'b0;
            r_byp_valid  <= 1'b0;
            r_filt_valid <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            r_rgb_valid  <= pair_valid_i & ~format_i[2];
            r_byp_valid  <= pair_valid_i & format_i[2];
            r_filt_valid <= r_rgb_valid;
            word_valid_o <= r_filt_valid | r_byp_valid;
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (pair_valid_i) begin
            r_r   <= s_r;
            r_g   <= s_g;
            r_b   <= s_b;
            r_byp <= s_byp;
        end
        if (r_rgb_valid) begin
            r_filt <= s_filt;
        end
        if (r_filt_valid) begin
            word_o <= out_word_t'(s_shifted);
        end else if (r_byp_valid) begin
            word_o <= out_word_t'(r_byp);
        end
    end

    // format comes from the register file and must be settled when a pixel arrives
    a_format_known : assert property (
        @(posedge s_cam_clk_dft) disable iff (!rstn_i)
        pair_valid_i |-> !$isunknown(format_i)
    );

endmodule

// ==== hw/cam_out_fifo.sv ====
// first-word-fall-through output buffer with saturating drop counter
`include "cam_settings.svh"

module cam_out_fifo #(
    parameter int DEPTH = `CAM_FIFO_DEPTH
) (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   wr_valid_i,
    input  logic [`CAM_WORD_W-1:0] wr_data_i,
    input  logic                   data_ready_i,
    output logic                   data_valid_o,
    output logic [`CAM_WORD_W-1:0] data_o,
    output logic [`CAM_CNT_W-1:0]  drop_count_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`CAM_WORD_W-1:0]  mem [DEPTH];
    logic [PTR_W-1:0]        r_wr_ptr;
    logic [PTR_W-1:0]        r_rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] r_count;
    logic                    s_full;
    logic                    s_push;
    logic                    s_pop;

    assign s_full       = (r_count == DEPTH);
    assign s_push       = wr_valid_i & ~s_full;
    assign s_pop        = data_valid_o & data_ready_i;
    assign data_valid_o = (r_count != '0);
    assign data_o       = mem[r_rd_ptr];

    always_ff @(posedge s_cam_clk_dft or negedge rstn_i) begin
        if (!rstn_i) begin
            r_wr_ptr     <= '0;
            r_rd_ptr     <= '0;
            r_count      <= '0;
            drop_count_o <= '0;
        end else if (flush_i) begin
            r_wr_ptr     <= '0;
            r_rd_ptr     <= '0;
            r_count      <= '0;
            drop_count_o <= '0;
        end else begin
            if (s_push) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (s_pop) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
            r_count <= r_count + s_push - s_pop;
            if (wr_valid_i && s_full && drop_count_o != '1) begin
                drop_count_o <= drop_count_o + 1'b1;   // saturates
            end
        end
    end

    always_ff @(posedge s_cam_clk_dft) begin
        if (s_push) begin
            mem[r_wr_ptr] <= wr_data_i;
        end
    end

    a_count_bound : assert property (
        @(posedge s_cam_clk_dft) disable iff (!rstn_i)
        r_count <= DEPTH
    );

endmodule

// ==== hw/cam_if_top.sv ====
// camera interface top with register file, frame control, pixel pipeline and buffer
`include "cam_settings.svh"

module cam_if_top (
    input  logic                   s_cam_clk_dft,
    input  logic                   rstn_i,
    input  logic                   cfg_valid_i,
    input  logic                   cfg_rwn_i,
    input  cam_cfg_pkg::cfg_addr_e cfg_addr_i,
    input  cam_cfg_pkg::cfg_word_t cfg_data_i,
    output cam_cfg_pkg::cfg_word_t cfg_data_o,
    output logic                   cfg_ready_o,
    input  cam_pix_pkg::pix_byte_t cam_data_i,
    input  logic                   cam_hsync_i,
    input  logic                   cam_vsync_i,
    output cam_pix_pkg::out_word_t data_o,
    output logic                   data_valid_o,
    input  logic                   data_ready_i,
    output logic                   frame_evt_o
);
    import cam_cfg_pkg::*;
    import cam_pix_pkg::*;

    logic        capture_en;
    logic        framedrop_en;
    frdrop_t     framedrop_val;
    logic        slice_en;
    cnt_t        slice_llx;
    cnt_t        slice_lly;
    cnt_t        slice_urx;
    cnt_t        slice_ury;
    cnt_t        rowlen;
    pix_format_e format;
    shift_t      shift;
    coeff_t      coeff_r;
    coeff_t      coeff_g;
    coeff_t      coeff_b;
    logic        vsync_pol;
    cnt_t        drop_count;
    logic        pair_valid;
    pix_byte_t   pair_msb;
    pix_byte_t   pair_lsb;
    logic        flush;
    logic        word_valid;
    out_word_t   word;

    cam_reg_file i_reg_file (
        .s_cam_clk_dft   ( s_cam_clk_dft ),
        .rstn_i          ( rstn_i        ),
        .cfg_valid_i     ( cfg_valid_i   ),
        .cfg_rwn_i       ( cfg_rwn_i     ),
        .cfg_addr_i      ( cfg_addr_i    ),
        .cfg_data_i      ( cfg_data_i    ),
        .drop_count_i    ( drop_count    ),
        .cfg_data_o      ( cfg_data_o    ),
        .cfg_ready_o     ( cfg_ready_o   ),
        .capture_en_o    ( capture_en    ),
        .framedrop_en_o  ( framedrop_en  ),
        .framedrop_val_o ( framedrop_val ),
        .slice_en_o      ( slice_en      ),
        .slice_llx_o     ( slice_llx     ),
        .slice_lly_o     ( slice_lly     ),
        .slice_urx_o     ( slice_urx     ),
        .slice_ury_o     ( slice_ury     ),
        .rowlen_o        ( rowlen        ),
        .format_o        ( format        ),
        .shift_o         ( shift         ),
        .coeff_r_o       ( coeff_r       ),
        .coeff_g_o       ( coeff_g       ),
        .coeff_b_o       ( coeff_b       ),
        .vsync_pol_o     ( vsync_pol     )
    );

    cam_frame_ctrl i_frame_ctrl (
        .s_cam_clk_dft   ( s_cam_clk_dft ),
        .rstn_i          ( rstn_i        ),
        .cam_data_i      ( cam_data_i    ),
        .cam_hsync_i     ( cam_hsync_i   ),
        .cam_vsync_i     ( cam_vsync_i   ),
        .capture_en_i    ( capture_en    ),
        .vsync_pol_i     ( vsync_pol     ),
        .framedrop_en_i  ( framedrop_en  ),
        .framedrop_val_i ( framedrop_val ),
        .slice_en_i      ( slice_en      ),
        .slice_llx_i     ( slice_llx     ),
        .slice_lly_i     ( slice_lly     ),
        .slice_urx_i     ( slice_urx     ),
        .slice_ury_i     ( slice_ury     ),
        .rowlen_i        ( rowlen        ),
        .pair_valid_o    ( pair_valid    ),
        .pair_msb_o      ( pair_msb      ),
        .pair_lsb_o      ( pair_lsb      ),
        .flush_o         ( flush         ),
        .frame_evt_o     ( frame_evt_o   )
    );

    cam_pixel_proc i_pixel_proc (
        .s_cam_clk_dft   ( s_cam_clk_dft ),
        .rstn_i          ( rstn_i        ),
        .pair_valid_i    ( pair_valid    ),
        .pair_msb_i      ( pair_msb      ),
        .pair_lsb_i      ( pair_lsb      ),
        .format_i        ( format        ),
        .shift_i         ( shift         ),
        .coeff_r_i       ( coeff_r       ),
        .coeff_g_i       ( coeff_g       ),
        .coeff_b_i       ( coeff_b       ),
        .word_valid_o    ( word_valid    ),
        .word_o          ( word          )
    );

    cam_out_fifo #(
        .DEPTH ( `CAM_FIFO_DEPTH )
    ) i_out_fifo (
        .s_cam_clk_dft   ( s_cam_clk_dft ),
        .rstn_i          ( rstn_i        ),
        .flush_i         ( flush         ),
        .wr_valid_i      ( word_valid    ),
        .wr_data_i       ( word          ),
        .data_ready_i    ( data_ready_i  ),
        .data_valid_o    ( data_valid_o  ),
        .data_o          ( data_o        ),
        .drop_count_o    ( drop_count    )
    );

endmodule

// ==== test/tb_cam_if.sv ====
// testbench for the camera interface with random frames, reference model and watchdog
`include "cam_settings.svh"

module tb_cam_if;
    import cam_cfg_pkg::*;
    import cam_pix_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int ROWS         = 4;
    localparam int WIDTH        = 6;     // pixels per row
    localparam int ROW_IDLE     = 3;
    localparam int FRAME_CYCLES = 3 + ROWS * (2 * WIDTH + ROW_IDLE) + 5;
    localparam int MAX_FRAMES   = 25;
    localparam int SETUP_CYCLES = 1000;  // register traffic, reset and drains
    localparam int WATCHDOG_T   = (MAX_FRAMES * FRAME_CYCLES + SETUP_CYCLES) * CLK_PERIOD + 2000;

    logic        s_cam_clk_dft = 1'b0;
    logic        rstn_i;
    logic        cfg_valid_i;
    logic        cfg_rwn_i;
    cfg_addr_e   cfg_addr_i;
    cfg_word_t   cfg_data_i;
    cfg_word_t   cfg_data_o;
    logic        cfg_ready_o;
    pix_byte_t   cam_data_i;
    logic        cam_hsync_i;
    logic        cam_vsync_i;
    out_word_t   data_o;
    logic        data_valid_o;
    logic        data_ready_i;
    logic        frame_evt_o;

    integer      seed = 17305;
    out_word_t   exp_q[$];
    string       test_name;
    int          err_word;
    int          err_reg;
    int          err_count;
    int          err_other;
    int          frame_idx;
    int          exp_evts;
    int          evt_count;
    int          exp_drops;
    int          buf_fill;

    // configuration currently loaded into the DUT
    pix_format_e cur_fmt;
    shift_t      cur_shift;
    coeff_t      cur_cr;
    coeff_t      cur_cg;
    coeff_t      cur_cb;
    logic        cur_pol;
    logic        dec_en;
    frdrop_t     dec_val;
    logic        slice_en;
    cnt_t        llx;
    cnt_t        lly;
    cnt_t        urx;
    cnt_t        ury;
    cnt_t        rowlen;
    logic        stall;      // ready held low for the whole frame

    cam_if_top i_dut (.*);

    always #(CLK_PERIOD / 2) s_cam_clk_dft = ~s_cam_clk_dft;

    function automatic int rand_int(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // grayscale or bypass word for one byte pair
    function automatic out_word_t expected_word(input pix_byte_t msb, input pix_byte_t lsb);
        int r;
        int g;
        int b;
        int sum;
        case (cur_fmt)
            RGB565: begin
                r = (msb >> 3) << 3;
                g = (((msb & 7) << 3) | (lsb >> 5)) << 2;
                b = (lsb & 31) << 3;
            end
            RGB555: begin
                r = ((msb >> 2) & 31) << 3;
                g = (((msb & 3) << 3) | (lsb >> 5)) << 3;
                b = (lsb & 31) << 3;
            end
            RGB444: begin
                r = (msb & 15) << 4;
                g = (lsb >> 4) << 4;
                b = (lsb & 15) << 4;
            end
            BYP_BE:  return out_word_t'({lsb, msb});
            default: return out_word_t'({msb, lsb});
        endcase
        sum = (r * cur_cr + g * cur_cg + b * cur_cb) % (1 << 17);
        if (cur_shift <= 9) begin
            sum = sum >> cur_shift;  // larger shifts mean no shift
        end
        return out_word_t'(sum % (1 << 16));
    endfunction

    task automatic check_word(input string name, input out_word_t exp, input out_word_t act);
        if (exp !== act) begin
            err_word++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input cfg_word_t exp, input cfg_word_t act);
        if (exp !== act) begin
            err_reg++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
        if (exp !== act) begin
            err_count++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic bus_access(input cfg_addr_e addr, input logic rwn, input cfg_word_t wdata,
                              output cfg_word_t rdata);
        int n;
        @(negedge s_cam_clk_dft);
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = rwn;
        cfg_addr_i  = addr;
        cfg_data_i  = wdata;
        @(negedge s_cam_clk_dft);
        cfg_valid_i = 1'b0;
        n = 0;
        while (!cfg_ready_o && n < 8) begin
            @(negedge s_cam_clk_dft);
            n++;
        end
        if (!cfg_ready_o) begin
            err_other++;
            $display("register bus gave no ready for address %0d", addr);
        end
        rdata = cfg_data_o;
    endtask

    task automatic reg_write(input cfg_addr_e addr, input cfg_word_t wdata);
        cfg_word_t unused;
        bus_access(addr, 1'b0, wdata, unused);
    endtask

    task automatic reg_read_check(input cfg_addr_e addr, input cfg_word_t exp, input string name);
        cfg_word_t rdata;
        bus_access(addr, 1'b1, '0, rdata);
        check_reg(name, exp, rdata);
    endtask

    task automatic set_defaults(input string name);
        test_name = name;
        cur_fmt   = BYP_LE;
        cur_shift = '0;
        cur_cr    = coeff_t'(rand_int(256));
        cur_cg    = coeff_t'(rand_int(256));
        cur_cb    = coeff_t'(rand_int(256));
        cur_pol   = 1'b0;
        dec_en    = 1'b0;
        dec_val   = '0;
        slice_en  = 1'b0;
        llx       = '0;
        lly       = '0;
        urx       = '0;
        ury       = '0;
        rowlen    = cnt_t'(WIDTH - 1);
        stall     = 1'b0;
    endtask

    task automatic apply_config();
        cfg_word_t glob;
        glob        = '0;
        glob[0]     = dec_en;
        glob[6:1]   = dec_val;
        glob[7]     = slice_en;
        glob[10:8]  = cur_fmt;
        glob[14:11] = cur_shift;
        glob[31]    = 1'b1;
        reg_write(REG_GLOB, '0);                 // capture off, buffer flushed
        reg_write(REG_VSYNC_POL, cfg_word_t'(cur_pol));
        @(negedge s_cam_clk_dft);
        cam_vsync_i = cur_pol;                   // inactive level
        reg_write(REG_LL, {lly, llx});
        reg_write(REG_UR, {ury, urx});
        reg_write(REG_SIZE, {rowlen, 16'h0000});
        reg_write(REG_FILTER, {8'h00, cur_cr, cur_cg, cur_cb});
        reg_write(REG_GLOB, glob);
        frame_idx = 0;
        exp_evts  = 0;
        evt_count = 0;
        exp_drops = 0;
    endtask

    // one frame of random pixels, expected words go to exp_q
    task automatic send_frame();
        pix_byte_t msb;
        pix_byte_t lsb;
        int        pix;
        int        col;
        int        row;
        logic      keep;
        keep = !dec_en || (frame_idx % (dec_val + 1) == 0);
        frame_idx++;
        exp_evts++;
        buf_fill = 0;
        pix      = 0;
        @(negedge s_cam_clk_dft);
        cam_vsync_i = ~cur_pol;
        repeat (2) @(negedge s_cam_clk_dft);
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                msb = pix_byte_t'(rand_int(256));
                lsb = pix_byte_t'(rand_int(256));
                cam_hsync_i = 1'b1;
                cam_data_i  = msb;
                @(negedge s_cam_clk_dft);
                cam_data_i = lsb;
                col = pix % (rowlen + 1);
                row = pix / (rowlen + 1);
                pix++;
                if (keep && (!slice_en || (col >= llx && col <= urx &&
                                           row >= lly && row <= ury))) begin
                    if (!stall || buf_fill < `CAM_FIFO_DEPTH) begin
                        exp_q.push_back(expected_word(msb, lsb));
                        buf_fill++;
                    end else begin
                        exp_drops++;             // buffer full
                    end
                end
                @(negedge s_cam_clk_dft);
            end
            cam_hsync_i = 1'b0;
            repeat (ROW_IDLE) @(negedge s_cam_clk_dft);
        end
        cam_vsync_i = cur_pol;
        repeat (5) @(negedge s_cam_clk_dft);
    endtask

    task automatic end_test();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            @(negedge s_cam_clk_dft);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_other++;
            $display("%s: %0d expected words never came out", test_name, exp_q.size());
            exp_q.delete();
        end
        repeat (4) @(negedge s_cam_clk_dft);
        check_count({test_name, " frame events"}, cnt_t'(exp_evts), cnt_t'(evt_count));
    endtask

    always @(posedge s_cam_clk_dft) begin
        if (rstn_i && data_valid_o && data_ready_i) begin
            if (exp_q.size() == 0) begin
                err_other++;
                $display("%s: output word %h arrived when none was expected", test_name, data_o);
            end else begin
                check_word(test_name, exp_q.pop_front(), data_o);
            end
        end
        if (rstn_i && frame_evt_o) begin
            evt_count++;
        end
    end

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired after %0d time units, the run did not finish", WATCHDOG_T);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        cfg_word_t regv [6];
        cfg_word_t rdata;
        int        addr;
        rstn_i       = 1'b0;
        cfg_valid_i  = 1'b0;
        cfg_rwn_i    = 1'b1;
        cfg_addr_i   = REG_GLOB;
        cfg_data_i   = '0;
        cam_data_i   = '0;
        cam_hsync_i  = 1'b0;
        cam_vsync_i  = 1'b0;
        data_ready_i = 1'b1;
        err_word     = 0;
        err_reg      = 0;
        err_count    = 0;
        err_other    = 0;
        evt_count    = 0;
        test_name    = "reset";
        repeat (10) @(negedge s_cam_clk_dft);
        rstn_i = 1'b1;

        test_name = "registers";
        for (int i = 0; i < 5; i++) begin
            regv[i] = $random(seed);
        end
        regv[0][31] = 1'b0;                      // keep capture off
        regv[5] = cfg_word_t'($random(seed) & 1);
        for (int i = 0; i < 6; i++) begin
            reg_write(cfg_addr_e'(i), regv[i]);
        end
        for (int i = 0; i < 6; i++) begin
            reg_read_check(cfg_addr_e'(i), regv[i], $sformatf("register %0d readback", i));
        end
        reg_write(REG_STATUS, $random(seed));
        reg_read_check(REG_STATUS, '0, "status after write");
        addr = 7 + rand_int(25);
        reg_write(cfg_addr_e'(addr), $random(seed));
        reg_read_check(cfg_addr_e'(addr), '0, "unmapped address");

        for (int f = 0; f < 3; f++) begin
            for (int j = 0; j < 3; j++) begin
                set_defaults($sformatf("grayscale format %0d frame %0d", f, j));
                cur_fmt   = pix_format_e'(f);
                cur_shift = shift_t'((j == 2) ? 10 + rand_int(6) : rand_int(10));
                apply_config();
                send_frame();
                end_test();
            end
        end

        for (int j = 0; j < 2; j++) begin
            set_defaults($sformatf("bypass %s", (j == 0) ? "LE" : "BE"));
            cur_fmt = (j == 0) ? BYP_LE : BYP_BE;
            cur_pol = 1'(j);                     // inverted vsync on the second pass
            apply_config();
            send_frame();
            send_frame();
            end_test();
        end

        for (int j = 0; j < 2; j++) begin
            set_defaults($sformatf("slice window %0d", j));
            cur_fmt   = (j == 0) ? BYP_BE : RGB565;
            cur_shift = shift_t'(rand_int(10));
            slice_en  = 1'b1;
            rowlen    = cnt_t'(2 + rand_int(WIDTH));
            llx       = cnt_t'(rand_int(rowlen + 1));
            urx       = cnt_t'(llx + rand_int(rowlen + 1 - llx));
            lly       = cnt_t'(rand_int(3));
            ury       = cnt_t'(lly + rand_int(3));
            apply_config();
            send_frame();
            end_test();
        end

        set_defaults("decimation");
        cur_fmt   = RGB444;
        cur_shift = shift_t'(rand_int(10));
        dec_en    = 1'b1;
        dec_val   = frdrop_t'(1 + rand_int(3));
        apply_config();
        repeat (2 * (dec_val + 1) + 1) send_frame();
        end_test();

        set_defaults("back pressure");
        stall = 1'b1;
        apply_config();
        @(negedge s_cam_clk_dft);
        data_ready_i = 1'b0;
        send_frame();
        @(negedge s_cam_clk_dft);
        data_ready_i = 1'b1;
        end_test();
        bus_access(REG_STATUS, 1'b1, '0, rdata);
        check_count("back pressure drops", cnt_t'(exp_drops), cnt_t'(rdata));

        $display("errors: %0d word, %0d register, %0d count, %0d other",
                 err_word, err_reg, err_count, err_other);
        if (err_word + err_reg + err_count + err_other == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/cam_cfg_pkg.sv
hw/cam_pix_pkg.sv
hw/cam_reg_file.sv
hw/cam_frame_ctrl.sv
hw/cam_pixel_proc.sv
hw/cam_out_fifo.sv
hw/cam_if_top.sv
test/tb_cam_if.sv

// ==== Bender.yml ====
package:
  name: cam_if

sources:
  - include_dirs:
      - hw
    files:
      - hw/cam_cfg_pkg.sv
      - hw/cam_pix_pkg.sv
      - hw/cam_reg_file.sv
      - hw/cam_frame_ctrl.sv
      - hw/cam_pixel_proc.sv
      - hw/cam_out_fifo.sv
      - hw/cam_if_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_cam_if.sv
